// File: rtl/cpu_pkg.sv
package cpu_pkg;

localparam int ISSUE_NUM  = 2;
localparam int DATA_W     = 32;
localparam int REG_ADDR_W = 5;
localparam int ALU_OP_W   = 4;

// primary opcodes
localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_ANDI    = 6'h0c;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_XORI    = 6'h0e;
localparam logic [5:0] OP_LUI     = 6'h0f;

// funct field under SPECIAL
localparam logic [5:0] FN_MFHI  = 6'h10;
localparam logic [5:0] FN_MFLO  = 6'h12;
localparam logic [5:0] FN_MULTU = 6'h19;
localparam logic [5:0] FN_ADDU  = 6'h21;
localparam logic [5:0] FN_SUBU  = 6'h23;
localparam logic [5:0] FN_AND   = 6'h24;
localparam logic [5:0] FN_OR    = 6'h25;
localparam logic [5:0] FN_XOR   = 6'h26;
localparam logic [5:0] FN_SLT   = 6'h2a;

localparam logic [ALU_OP_W-1:0] ALU_NOP  = 4'd0;
localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd1;
localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd2;
localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd3;
localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd4;
localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd7;
localparam logic [ALU_OP_W-1:0] ALU_MULT = 4'd8;
localparam logic [ALU_OP_W-1:0] ALU_MFHI = 4'd9;
localparam logic [ALU_OP_W-1:0] ALU_MFLO = 4'd10;

// one instruction word, seen as R-type or I-type
typedef union packed {
	struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r;
	struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i;
} instr_t;

endpackage

// File: rtl/regfile.sv
`timescale 1ns/100ps

module regfile import cpu_pkg::*; #(
	parameter int REG_NUM     = 32,
	parameter int READ_PORTS  = 4,
	parameter int WRITE_PORTS = 2
) (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic [WRITE_PORTS-1:0]                       we,
	input  logic [WRITE_PORTS-1:0][$clog2(REG_NUM)-1:0]  waddr,
	input  logic [WRITE_PORTS-1:0][DATA_W-1:0]           wdata,
	input  logic [READ_PORTS-1:0][$clog2(REG_NUM)-1:0]   raddr,
	output logic [READ_PORTS-1:0][DATA_W-1:0]            rdata
);

logic [REG_NUM-1:0][DATA_W-1:0] regs;

// later write port overrides an earlier one
always_ff @(posedge clk) begin
	if (rst) begin
		regs <= '0;
	end else begin
		for (int w = 0; w < WRITE_PORTS; w++) begin
			if (we[w] && waddr[w] != '0) begin
				regs[waddr[w]] <= wdata[w];
			end
		end
	end
end

// old value on a same-cycle read
always_comb begin
	for (int r = 0; r < READ_PORTS; r++) begin
		if (raddr[r] == '0) begin
			rdata[r] = '0;
		end else begin
			rdata[r] = regs[raddr[r]];
		end
	end
end

endmodule

// File: rtl/decode_and_issue.sv
`timescale 1ns/100ps

module decode_and_issue import cpu_pkg::*; (
	input  instr_t [ISSUE_NUM-1:0]                   fetch_instr,
	input  logic   [ISSUE_NUM-1:0]                   fetch_valid,
	output logic   [1:0]                             issue_num,
	output logic   [2*ISSUE_NUM-1:0][REG_ADDR_W-1:0] reg_raddr,
	input  logic   [2*ISSUE_NUM-1:0][DATA_W-1:0]     reg_rdata,
	input  logic   [ISSUE_NUM-1:0]                   ex_we,
	input  logic   [ISSUE_NUM-1:0][REG_ADDR_W-1:0]   ex_rd,
	input  logic   [ISSUE_NUM-1:0][DATA_W-1:0]       ex_wdata,
	input  logic   [ISSUE_NUM-1:0]                   wb_we,
	input  logic   [ISSUE_NUM-1:0][REG_ADDR_W-1:0]   wb_rd,
	input  logic   [ISSUE_NUM-1:0][DATA_W-1:0]       wb_wdata,
	output logic   [ISSUE_NUM-1:0]                   id_valid,
	output logic   [ISSUE_NUM-1:0][ALU_OP_W-1:0]     id_alu_op,
	output logic   [ISSUE_NUM-1:0][REG_ADDR_W-1:0]   id_rd,
	output logic   [ISSUE_NUM-1:0]                   id_we,
	output logic   [ISSUE_NUM-1:0]                   id_hilo_we,
	output logic   [ISSUE_NUM-1:0][DATA_W-1:0]       id_a,
	output logic   [ISSUE_NUM-1:0][DATA_W-1:0]       id_b
);

logic [ISSUE_NUM-1:0][ALU_OP_W-1:0]   dec_op;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] dec_rs;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] dec_rt;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] dec_dst;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     dec_imm;
logic [ISSUE_NUM-1:0]                 dec_we;
logic [ISSUE_NUM-1:0]                 dec_hilo_we;
logic [ISSUE_NUM-1:0]                 dec_hilo_re;
logic [ISSUE_NUM-1:0]                 dec_rs_re;
logic [ISSUE_NUM-1:0]                 dec_rt_re;
logic [ISSUE_NUM-1:0]                 dec_use_imm;
logic [ISSUE_NUM-1:0]                 lane_issue;
logic                                 raw_hazard;
logic                                 hilo_hazard;

always_comb begin
	for (int k = 0; k < ISSUE_NUM; k++) begin
		dec_op[k]      = ALU_NOP;
		dec_rs[k]      = fetch_instr[k].r.rs;
		dec_rt[k]      = fetch_instr[k].r.rt;
		dec_imm[k]     = '0;
		dec_use_imm[k] = 1'b0;
		if (fetch_instr[k].r.opcode == OP_SPECIAL) begin
			dec_dst[k] = fetch_instr[k].r.rd;
			case (fetch_instr[k].r.funct)
				FN_ADDU:  dec_op[k] = ALU_ADD;
				FN_SUBU:  dec_op[k] = ALU_SUB;
				FN_AND:   dec_op[k] = ALU_AND;
				FN_OR:    dec_op[k] = ALU_OR;
				FN_XOR:   dec_op[k] = ALU_XOR;
				FN_SLT:   dec_op[k] = ALU_SLT;
				FN_MULTU: dec_op[k] = ALU_MULT;
				FN_MFHI:  dec_op[k] = ALU_MFHI;
				FN_MFLO:  dec_op[k] = ALU_MFLO;
				default:  dec_op[k] = ALU_NOP;
			endcase
			dec_rs_re[k] = !(dec_op[k] inside {ALU_NOP, ALU_MFHI, ALU_MFLO});
			dec_rt_re[k] = dec_rs_re[k];
			dec_we[k]    = dec_op[k] != ALU_NOP && dec_op[k] != ALU_MULT;
		end else begin
			// I-type writes rt
			dec_dst[k]     = fetch_instr[k].i.rt;
			dec_use_imm[k] = 1'b1;
			dec_imm[k]     = {{(DATA_W-16){1'b0}}, fetch_instr[k].i.imm};
			case (fetch_instr[k].i.opcode)
				OP_ADDIU: begin
					dec_op[k]  = ALU_ADD;
					dec_imm[k] = {{(DATA_W-16){fetch_instr[k].i.imm[15]}},
						fetch_instr[k].i.imm};
				end
				OP_ANDI: dec_op[k] = ALU_AND;
				OP_ORI:  dec_op[k] = ALU_OR;
				OP_XORI: dec_op[k] = ALU_XOR;
				OP_LUI:  dec_op[k] = ALU_LUI;
				default: dec_op[k] = ALU_NOP;
			endcase
			dec_rs_re[k] = dec_op[k] inside {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
			dec_rt_re[k] = 1'b0;
			dec_we[k]    = dec_op[k] != ALU_NOP;
		end
		dec_hilo_we[k] = dec_op[k] == ALU_MULT;
		dec_hilo_re[k] = dec_op[k] inside {ALU_MFHI, ALU_MFLO};
		reg_raddr[2*k]   = dec_rs[k];
		reg_raddr[2*k+1] = dec_rt[k];
	end
end

// pairing checks between the two entries
assign raw_hazard = dec_we[0] && dec_dst[0] != '0 &&
	((dec_rs_re[1] && dec_rs[1] == dec_dst[0]) ||
	 (dec_rt_re[1] && dec_rt[1] == dec_dst[0]));
assign hilo_hazard = dec_hilo_we[0] && (dec_hilo_re[1] || dec_hilo_we[1]);

always_comb begin
	if (!fetch_valid[0]) begin
		issue_num = 2'd0;
	end else if (fetch_valid[1] && !raw_hazard && !hilo_hazard) begin
		issue_num = 2'd2;
	end else begin
		issue_num = 2'd1;
	end
end

assign lane_issue[0] = issue_num != 2'd0;
assign lane_issue[1] = issue_num == 2'd2;

// newest producer wins, EX lane 1 first
function automatic logic [DATA_W-1:0] fwd(input logic [REG_ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] rf_val);
	logic [DATA_W-1:0] v;
	v = rf_val;
	for (int l = 0; l < ISSUE_NUM; l++) begin
		if (wb_we[l] && wb_rd[l] == addr) v = wb_wdata[l];
	end
	for (int l = 0; l < ISSUE_NUM; l++) begin
		if (ex_we[l] && ex_rd[l] == addr) v = ex_wdata[l];
	end
	if (addr == '0) v = '0;
	return v;
endfunction

always_comb begin
	for (int k = 0; k < ISSUE_NUM; k++) begin
		id_valid[k]   = lane_issue[k];
		id_alu_op[k]  = lane_issue[k] ? dec_op[k] : ALU_NOP;
		id_rd[k]      = dec_dst[k];
		id_we[k]      = lane_issue[k] & dec_we[k];
		id_hilo_we[k] = lane_issue[k] & dec_hilo_we[k];
		id_a[k]       = fwd(dec_rs[k], reg_rdata[2*k]);
		id_b[k]       = dec_use_imm[k] ? dec_imm[k] : fwd(dec_rt[k], reg_rdata[2*k+1]);
	end
end

endmodule

// File: rtl/instr_exec.sv
`timescale 1ns/100ps

module instr_exec import cpu_pkg::*; (
	input  logic                  valid,
	input  logic [ALU_OP_W-1:0]   alu_op,
	input  logic [REG_ADDR_W-1:0] rd,
	input  logic                  we,
	input  logic                  hilo_we,
	input  logic [DATA_W-1:0]     a,
	input  logic [DATA_W-1:0]     b,
	input  logic [2*DATA_W-1:0]   hilo,
	output logic                  res_we,
	output logic [REG_ADDR_W-1:0] res_rd,
	output logic [DATA_W-1:0]     res_wdata,
	output logic                  res_hilo_we,
	output logic [2*DATA_W-1:0]   res_hilo_wdata
);

logic [DATA_W-1:0]   alu_res;
logic [2*DATA_W-1:0] product;

// unsigned 32x32 for MULTU
assign product = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};

always_comb begin
	case (alu_op)
		ALU_ADD: begin
			alu_res = a + b;
		end
		ALU_SUB: begin
			alu_res = a - b;
		end
		ALU_AND: begin
			alu_res = a & b;
		end
		ALU_OR: begin
			alu_res = a | b;
		end
		ALU_XOR: begin
			alu_res = a ^ b;
		end
		ALU_SLT: begin
			// signed compare
			alu_res = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
		end
		ALU_LUI: begin
			alu_res = {b[DATA_W/2-1:0], {(DATA_W/2){1'b0}}};
		end
		ALU_MFHI: begin
			alu_res = hilo[2*DATA_W-1:DATA_W];
		end
		ALU_MFLO: begin
			alu_res = hilo[DATA_W-1:0];
		end
		ALU_NOP, ALU_MULT: begin
			// no register result
			alu_res = '0;
		end
		default: begin
			alu_res = '0;
		end
	endcase
end

// bubbles leave nothing behind
assign res_we         = valid & we;
assign res_rd         = valid ? rd : '0;
assign res_wdata      = valid ? alu_res : '0;
assign res_hilo_we    = valid & hilo_we;
assign res_hilo_wdata = valid ? product : '0;

endmodule

// File: rtl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
	parameter int REG_NUM = 32
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  instr_t [ISSUE_NUM-1:0]                 fetch_instr,
	input  logic   [ISSUE_NUM-1:0]                 fetch_valid,
	output logic   [1:0]                           issue_num,
	output logic   [ISSUE_NUM-1:0]                 commit_en,
	output logic   [ISSUE_NUM-1:0][REG_ADDR_W-1:0] commit_rd,
	output logic   [ISSUE_NUM-1:0][DATA_W-1:0]     commit_wdata,
	output logic   [2*DATA_W-1:0]                  hilo
);

// register file ports
logic [2*ISSUE_NUM-1:0][REG_ADDR_W-1:0] reg_raddr;
logic [2*ISSUE_NUM-1:0][DATA_W-1:0]     reg_rdata;

// decode outputs
logic [1:0]                           dec_issue_num;
logic [ISSUE_NUM-1:0]                 id_valid;
logic [ISSUE_NUM-1:0][ALU_OP_W-1:0]   id_alu_op;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] id_rd;
logic [ISSUE_NUM-1:0]                 id_we;
logic [ISSUE_NUM-1:0]                 id_hilo_we;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     id_a;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     id_b;

// ID/EX stage
logic [ISSUE_NUM-1:0]                 ex_valid;
logic [ISSUE_NUM-1:0][ALU_OP_W-1:0]   ex_alu_op;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] ex_rd;
logic [ISSUE_NUM-1:0]                 ex_we;
logic [ISSUE_NUM-1:0]                 ex_hilo_we;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     ex_a;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     ex_b;

// execute results
logic [ISSUE_NUM-1:0]                 res_we;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] res_rd;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     res_wdata;
logic [ISSUE_NUM-1:0]                 res_hilo_we;
logic [ISSUE_NUM-1:0][2*DATA_W-1:0]   res_hilo_wdata;

// EX/WB stage
logic [ISSUE_NUM-1:0]                 wb_we;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] wb_rd;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     wb_wdata;
logic [ISSUE_NUM-1:0]                 wb_hilo_we;
logic [ISSUE_NUM-1:0][2*DATA_W-1:0]   wb_hilo_wdata;

logic [2*DATA_W-1:0] hilo_reg;
logic [2*DATA_W-1:0] hilo_fwd;

regfile #(
	.REG_NUM     ( REG_NUM     ),
	.READ_PORTS  ( 2*ISSUE_NUM ),
	.WRITE_PORTS ( ISSUE_NUM   )
) regfile_inst (
	.clk,
	.rst,
	.we    ( wb_we     ),
	.waddr ( wb_rd     ),
	.wdata ( wb_wdata  ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

decode_and_issue decode_issue_inst (
	.fetch_instr,
	.fetch_valid,
	.issue_num ( dec_issue_num ),
	.reg_raddr,
	.reg_rdata,
	.ex_we    ( res_we    ),
	.ex_rd    ( res_rd    ),
	.ex_wdata ( res_wdata ),
	.wb_we,
	.wb_rd,
	.wb_wdata,
	.id_valid,
	.id_alu_op,
	.id_rd,
	.id_we,
	.id_hilo_we,
	.id_a,
	.id_b
);

always_ff @(posedge clk) begin
	if (rst) begin
		ex_valid   <= '0;
		ex_alu_op  <= '0;
		ex_rd      <= '0;
		ex_we      <= '0;
		ex_hilo_we <= '0;
		ex_a       <= '0;
		ex_b       <= '0;
	end else begin
		ex_valid   <= id_valid;
		ex_alu_op  <= id_alu_op;
		ex_rd      <= id_rd;
		ex_we      <= id_we;
		ex_hilo_we <= id_hilo_we;
		ex_a       <= id_a;
		ex_b       <= id_b;
	end
end

// a HI/LO write sitting in WB is newer than the register
always_comb begin
	hilo_fwd = hilo_reg;
	for (int l = 0; l < ISSUE_NUM; l++) begin
		if (wb_hilo_we[l]) hilo_fwd = wb_hilo_wdata[l];
	end
end

for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_exec
	instr_exec exec_inst (
		.valid          ( ex_valid[i]       ),
		.alu_op         ( ex_alu_op[i]      ),
		.rd             ( ex_rd[i]          ),
		.we             ( ex_we[i]          ),
		.hilo_we        ( ex_hilo_we[i]     ),
		.a              ( ex_a[i]           ),
		.b              ( ex_b[i]           ),
		.hilo           ( hilo_fwd          ),
		.res_we         ( res_we[i]         ),
		.res_rd         ( res_rd[i]         ),
		.res_wdata      ( res_wdata[i]      ),
		.res_hilo_we    ( res_hilo_we[i]    ),
		.res_hilo_wdata ( res_hilo_wdata[i] )
	);
end

always_ff @(posedge clk) begin
	if (rst) begin
		wb_we         <= '0;
		wb_rd         <= '0;
		wb_wdata      <= '0;
		wb_hilo_we    <= '0;
		wb_hilo_wdata <= '0;
	end else begin
		wb_we         <= res_we;
		wb_rd         <= res_rd;
		wb_wdata      <= res_wdata;
		wb_hilo_we    <= res_hilo_we;
		wb_hilo_wdata <= res_hilo_wdata;
	end
end

// later lane already wins inside hilo_fwd
always_ff @(posedge clk) begin
	if (rst) begin
		hilo_reg <= '0;
	end else if (|wb_hilo_we) begin
		hilo_reg <= hilo_fwd;
	end
end

// nothing is taken while the core is held in reset
assign issue_num    = rst ? 2'd0 : dec_issue_num;
assign hilo         = hilo_reg;
assign commit_en    = wb_we;
assign commit_rd    = wb_rd;
assign commit_wdata = wb_wdata;

endmodule

// File: sim/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb import cpu_pkg::*; ();

localparam int MAX_CYCLES  = 300;
localparam int COMMIT_WAIT = 4;
localparam int RAND_COUNT  = 40;

logic                                 clk;
logic                                 rst;
instr_t [ISSUE_NUM-1:0]               fetch_instr;
logic   [ISSUE_NUM-1:0]               fetch_valid;
logic   [1:0]                         issue_num;
logic [ISSUE_NUM-1:0]                 commit_en;
logic [ISSUE_NUM-1:0][REG_ADDR_W-1:0] commit_rd;
logic [ISSUE_NUM-1:0][DATA_W-1:0]     commit_wdata;
logic [2*DATA_W-1:0]                  hilo;

// program table with its expected values
string                 tbl_name[$];
instr_t                tbl_instr[$];
logic [REG_ADDR_W-1:0] tbl_rd[$];
logic [2*DATA_W-1:0]   tbl_val[$];
// issued entries still waiting for a commit or a HI/LO update
int                    q_idx[$];
int                    q_due[$];
int                    h_idx[$];
int                    h_due[$];
logic [DATA_W-1:0]     model_rf[32];
logic [2*DATA_W-1:0]   model_hilo;
int                    seed = 11752;
int                    errors = 0;
int                    timeouts = 0;

cpu_core #(
	.REG_NUM ( 32 )
) i_dut (
	.clk,
	.rst,
	.fetch_instr,
	.fetch_valid,
	.issue_num,
	.commit_en,
	.commit_rd,
	.commit_wdata,
	.hilo
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic logic [31:0] r_word(input logic [5:0] fn, input int rd, rs, rt);
	return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, rs,
		input logic [15:0] imm);
	return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic bit is_multu(input instr_t w);
	return w.r.opcode == OP_SPECIAL && w.r.funct == FN_MULTU;
endfunction

function automatic bit is_move(input instr_t w);
	return w.r.opcode == OP_SPECIAL && (w.r.funct == FN_MFHI || w.r.funct == FN_MFLO);
endfunction

function automatic logic [REG_ADDR_W-1:0] dest_of(input instr_t w);
	return (w.r.opcode == OP_SPECIAL) ? w.r.rd : w.i.rt;
endfunction

// how many of the two head entries may issue together
function automatic logic [1:0] rule_issue(input instr_t a, b, input logic va, vb);
	logic [REG_ADDR_W-1:0] d;
	bit                    reads;
	d = dest_of(a);
	if (b.r.opcode == OP_SPECIAL) begin
		reads = !is_move(b) && (b.r.rs == d || b.r.rt == d);
	end else begin
		reads = b.i.opcode != OP_LUI && b.i.rs == d;
	end
	if (va !== 1'b1) return 2'd0;
	if (vb !== 1'b1) return 2'd1;
	if (!is_multu(a) && d != '0 && reads) return 2'd1;
	if (is_multu(a) && (is_multu(b) || is_move(b))) return 2'd1;
	return 2'd2;
endfunction

// architectural result in program order
function automatic logic [2*DATA_W-1:0] run_model(input instr_t w);
	logic [DATA_W-1:0] s;
	logic [DATA_W-1:0] t;
	logic [DATA_W-1:0] imm_z;
	logic [DATA_W-1:0] res;
	s     = model_rf[w.r.rs];
	t     = model_rf[w.r.rt];
	imm_z = {16'h0, w.i.imm};
	res   = '0;
	if (w.r.opcode == OP_SPECIAL) begin
		case (w.r.funct)
			FN_ADDU:  res = s + t;
			FN_SUBU:  res = s - t;
			FN_AND:   res = s & t;
			FN_OR:    res = s | t;
			FN_XOR:   res = s ^ t;
			FN_SLT:   res = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
			FN_MFHI:  res = model_hilo[63:32];
			FN_MFLO:  res = model_hilo[31:0];
			FN_MULTU: model_hilo = {32'h0, s} * {32'h0, t};
			default:  res = '0;
		endcase
	end else begin
		case (w.i.opcode)
			OP_ADDIU: res = s + {{16{w.i.imm[15]}}, w.i.imm};
			OP_ANDI:  res = s & imm_z;
			OP_ORI:   res = s | imm_z;
			OP_XORI:  res = s ^ imm_z;
			OP_LUI:   res = {w.i.imm, 16'h0};
			default:  res = '0;
		endcase
	end
	if (is_multu(w)) return model_hilo;
	if (dest_of(w) != '0) model_rf[dest_of(w)] = res;
	return {32'h0, res};
endfunction

task automatic add_entry(input string name, input logic [31:0] word, input int rd,
		input logic [63:0] val, input bit from_model);
	logic [2*DATA_W-1:0] m;
	m = run_model(word);
	tbl_name.push_back(name);
	tbl_instr.push_back(word);
	tbl_rd.push_back(from_model ? dest_of(word) : rd[4:0]);
	tbl_val.push_back(from_model ? m : val);
endtask

task automatic check_word(input string name, input logic [DATA_W-1:0] exp, act);
	if (act !== exp) begin
		$display("Fail %s: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp, act);
	if (act !== exp) begin
		$display("Fail %s rd: expected %0d, actual %0d", name, exp, act);
		errors++;
	end
endtask

task automatic check_hilo(input string name, input logic [2*DATA_W-1:0] exp, act);
	if (act !== exp) begin
		$display("Fail %s hilo: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_count(input string name, input logic [1:0] exp, act);
	if (act !== exp) begin
		$display("Fail %s issue_num: expected %0d, actual %0d", name, exp, act);
		errors++;
	end
endtask

task automatic build_table();
	logic [5:0]  r_fn[6];
	logic [5:0]  i_op[5];
	logic [31:0] word;
	logic [31:0] rnd;
	int          sel;
	int          rd;
	int          rs;
	int          rt;
	r_fn = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
	i_op = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	add_entry("addiu_sext", i_word(OP_ADDIU, 1, 0, 16'hffff), 1, 64'hffff_ffff, 0);
	add_entry("ori_zext", i_word(OP_ORI, 2, 0, 16'h8001), 2, 64'h8001, 0);
	add_entry("lui", i_word(OP_LUI, 3, 0, 16'h1234), 3, 64'h1234_0000, 0);
	add_entry("addu_fwd", r_word(FN_ADDU, 4, 3, 2), 4, 64'h1234_8001, 0);
	add_entry("slt_neg", r_word(FN_SLT, 5, 1, 2), 5, 64'h1, 0);
	add_entry("slt_pos", r_word(FN_SLT, 6, 2, 1), 6, 64'h0, 0);
	add_entry("andi_zext", i_word(OP_ANDI, 7, 1, 16'h8f0f), 7, 64'h8f0f, 0);
	add_entry("xori_fwd", i_word(OP_XORI, 8, 7, 16'hffff), 8, 64'h70f0, 0);
	add_entry("subu", r_word(FN_SUBU, 9, 4, 3), 9, 64'h8001, 0);
	add_entry("and", r_word(FN_AND, 10, 1, 4), 10, 64'h1234_8001, 0);
	add_entry("or_fwd", r_word(FN_OR, 11, 8, 2), 11, 64'hf0f1, 0);
	add_entry("xor_fwd", r_word(FN_XOR, 12, 11, 10), 12, 64'h1234_70f0, 0);
	add_entry("multu_a", r_word(FN_MULTU, 0, 1, 4), 0, 64'h12348000_edcb7fff, 0);
	add_entry("mfhi_next", r_word(FN_MFHI, 13, 0, 0), 13, 64'h1234_8000, 0);
	add_entry("mflo_next", r_word(FN_MFLO, 14, 0, 0), 14, 64'hedcb_7fff, 0);
	add_entry("multu_b", r_word(FN_MULTU, 0, 2, 2), 0, 64'h4001_0001, 0);
	add_entry("addiu_gap", i_word(OP_ADDIU, 16, 0, 16'd5), 16, 64'd5, 0);
	add_entry("addiu_dep", i_word(OP_ADDIU, 17, 16, 16'd1), 17, 64'd6, 0);
	add_entry("addu_dep", r_word(FN_ADDU, 18, 17, 16), 18, 64'd11, 0);
	add_entry("mflo_gap", r_word(FN_MFLO, 15, 0, 0), 15, 64'h4001_0001, 0);
	add_entry("multu_c", r_word(FN_MULTU, 0, 4, 2), 0, 64'h0000091a_52350001, 0);
	add_entry("mfhi_pair", r_word(FN_MFHI, 19, 0, 0), 19, 64'h091a, 0);
	add_entry("mflo_pair", r_word(FN_MFLO, 20, 0, 0), 20, 64'h5235_0001, 0);
	add_entry("write_r0", i_word(OP_ADDIU, 0, 0, 16'd7), 0, 64'd7, 0);
	add_entry("read_r0_id", i_word(OP_ADDIU, 23, 0, 16'h11), 23, 64'h11, 0);
	add_entry("read_r0_ex", r_word(FN_ADDU, 22, 0, 23), 22, 64'h11, 0);
	add_entry("same_dst_l0", r_word(FN_ADDU, 24, 22, 0), 24, 64'h11, 0);
	add_entry("same_dst_l1", i_word(OP_ADDIU, 24, 0, 16'd2), 24, 64'd2, 0);
	add_entry("lane1_ex_a", r_word(FN_ADDU, 25, 24, 0), 25, 64'd2, 0);
	add_entry("lane1_ex_b", r_word(FN_ADDU, 26, 24, 24), 26, 64'd4, 0);
	add_entry("lane1_wb", r_word(FN_ADDU, 27, 24, 0), 27, 64'd2, 0);
	// no entry reads what its predecessor writes
	for (int j = 0; j < RAND_COUNT; j++) begin
		sel = {$random(seed)} % 11;
		rd  = 1 + {$random(seed)} % 31;
		rs  = {$random(seed)} % 32;
		rt  = {$random(seed)} % 32;
		if (rs == dest_of(tbl_instr[$])) rs = rs ^ 1;
		if (rt == dest_of(tbl_instr[$])) rt = rt ^ 1;
		if (sel < 6) begin
			word = r_word(r_fn[sel], rd, rs, rt);
		end else begin
			rnd  = $random(seed);
			word = i_word(i_op[sel-6], rd, rs, rnd[15:0]);
		end
		add_entry($sformatf("rand_%0d", j), word, 0, '0, 1);
	end
endtask

task automatic drive_head(input int head);
	fetch_valid = '0;
	fetch_instr = '0;
	for (int k = 0; k < ISSUE_NUM; k++) begin
		if (head + k < tbl_instr.size()) begin
			fetch_instr[k] = tbl_instr[head+k];
			fetch_valid[k] = 1'b1;
		end
	end
endtask

// lane 0 is older, so it is matched first
task automatic collect_commits(input int cyc);
	for (int k = 0; k < ISSUE_NUM; k++) begin
		if (commit_en[k] === 1'b1) begin
			if (q_idx.size() == 0) begin
				$display("unexpected commit on lane %0d in cycle %0d", k, cyc);
				errors++;
			end else begin
				check_rd(tbl_name[q_idx[0]], tbl_rd[q_idx[0]], commit_rd[k]);
				check_word(tbl_name[q_idx[0]], tbl_val[q_idx[0]][DATA_W-1:0], commit_wdata[k]);
				q_idx.pop_front();
				q_due.pop_front();
			end
		end
	end
	if (q_due.size() > 0 && cyc > q_due[0] + COMMIT_WAIT) begin
		$display("timeout waiting for the commit of %s", tbl_name[q_idx[0]]);
		timeouts++;
	end
endtask

initial begin
	int head;
	int cyc;
	int take;
	rst         = 1'b1;
	fetch_valid = '0;
	fetch_instr = '0;
	model_hilo  = '0;
	for (int r = 0; r < 32; r++) begin
		model_rf[r] = '0;
	end
	build_table();
	// valid entries are offered but must not be taken in reset
	drive_head(0);
	repeat (10) begin
		@(negedge clk);
		check_count("reset", 2'd0, issue_num);
		if (commit_en !== '0) begin
			$display("commit_en is not low during reset");
			errors++;
		end
	end
	rst  = 1'b0;
	head = 0;
	cyc  = 0;
	drive_head(head);
	while ((head < tbl_instr.size() || q_idx.size() > 0 || h_idx.size() > 0) &&
			timeouts == 0 && cyc < MAX_CYCLES) begin
		@(negedge clk);
		cyc++;
		collect_commits(cyc);
		// MULTU product lands in HI/LO two edges after issue
		while (h_idx.size() > 0 && h_due[0] <= cyc) begin
			check_hilo(tbl_name[h_idx[0]], tbl_val[h_idx[0]], hilo);
			h_idx.pop_front();
			h_due.pop_front();
		end
		check_count(head < tbl_instr.size() ? tbl_name[head] : "idle",
			rule_issue(fetch_instr[0], fetch_instr[1], fetch_valid[0], fetch_valid[1]),
			issue_num);
		take = issue_num;
		if (take > $countones(fetch_valid)) take = $countones(fetch_valid);
		for (int k = 0; k < take; k++) begin
			if (is_multu(tbl_instr[head+k])) begin
				h_idx.push_back(head + k);
				h_due.push_back(cyc + 2);
			end else begin
				q_idx.push_back(head + k);
				q_due.push_back(cyc + 1);
			end
		end
		head += take;
		drive_head(head);
	end
	if (cyc >= MAX_CYCLES) begin
		$display("run did not finish within %0d cycles", MAX_CYCLES);
		timeouts++;
	end
	$display("errors: %0d, timeouts: %0d", errors, timeouts);
	if (errors == 0 && timeouts == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

endmodule

// File: filelist.f
rtl/cpu_pkg.sv
rtl/regfile.sv
rtl/decode_and_issue.sv
rtl/instr_exec.sv
rtl/cpu_core.sv
sim/cpu_core_tb.sv
